// ==== wlcPkg.sv ====
package wlcPkg;

    // Workload format codes
    typedef enum logic [2:0] {
        FmtUnknown = 3'd0,
        FmtCompute = 3'd1,
        FmtMemory  = 3'd2,
        FmtControl = 3'd3,
        FmtMixed   = 3'd4,
        FmtIdle    = 3'd5
    } wlFormat_e;

    typedef logic [6:0] opcode_t;

    // RV32 major opcodes by class
    localparam opcode_t OpAluReg = 7'b0110011;  // Compute
    localparam opcode_t OpAluImm = 7'b0010011;
    localparam opcode_t OpLoad   = 7'b0000011;  // Memory
    localparam opcode_t OpStore  = 7'b0100011;
    localparam opcode_t OpBranch = 7'b1100011;  // Control
    localparam opcode_t OpJal    = 7'b1101111;
    localparam opcode_t OpJalr   = 7'b1100111;

    typedef struct packed {
        logic    valid;
        opcode_t opcode;
    } instrBeat_t;

    // One finished window, idle set when closed by an idle run
    typedef struct packed {
        logic [7:0] total;
        logic [7:0] computeCnt;
        logic [7:0] memCnt;
        logic [7:0] controlCnt;
        logic       idle;
    } winSummary_t;

    typedef struct packed {
        wlFormat_e  format;
        logic [3:0] confidence;
        logic [7:0] computeToll;
        logic [7:0] memToll;
        logic [7:0] controlToll;
    } classResult_t;

    localparam int DefWindowLen     = 16;
    localparam int DefIdleLimit     = 24;
    localparam int DefFifoDepth     = 4;
    localparam int DefConfThreshold = 4;

    // Decision thresholds, tolls run 0..255
    localparam int TollScale      = 200;
    localparam int DominantLevel  = 150;
    localparam int DominantMargin = 80;
    localparam int MixedLevel     = 50;

endpackage

// ==== opcodeWindow.sv ====
module opcodeWindow #(
    parameter int WindowLen = 16,
    parameter int IdleLimit = 24,
    parameter int FifoDepth = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  wlcPkg::instrBeat_t  instr,
    input  logic                creditReturn,
    output wlcPkg::winSummary_t summary,
    output logic                summaryValid,
    output logic [15:0]         droppedWindows
);
    import wlcPkg::*;

    localparam int IdleW   = $clog2(IdleLimit + 1);
    localparam int CreditW = $clog2(FifoDepth + 1);

    logic [7:0]         total;
    logic [7:0]         computeCnt;
    logic [7:0]         memCnt;
    logic [7:0]         controlCnt;
    logic [IdleW-1:0]   idleCnt;
    logic [CreditW-1:0] credits;

    logic [7:0] nextTotal;
    logic [7:0] nextCompute;
    logic [7:0] nextMem;
    logic [7:0] nextControl;
    logic       windowFull;
    logic       idleFire;
    logic       windowEnd;
    logic       canSend;

    // Counts including the current beat
    always_comb begin
        nextTotal   = total;
        nextCompute = computeCnt;
        nextMem     = memCnt;
        nextControl = controlCnt;
        if (instr.valid) begin
            nextTotal = total + 8'd1;
            case (instr.opcode)
                OpAluReg, OpAluImm:       nextCompute = computeCnt + 8'd1;
                OpLoad, OpStore:          nextMem = memCnt + 8'd1;
                OpBranch, OpJal, OpJalr:  nextControl = controlCnt + 8'd1;
                default: ;  // Unclassified, total only
            endcase
        end
    end

    assign windowFull = instr.valid && (nextTotal == 8'(WindowLen));
    // Fires on the IdleLimit-th empty cycle, counter then parks at the limit
    assign idleFire   = !instr.valid && (idleCnt == IdleW'(IdleLimit - 1));
    assign windowEnd  = windowFull || idleFire;
    assign canSend    = (credits != '0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            total          <= '0;
            computeCnt     <= '0;
            memCnt         <= '0;
            controlCnt     <= '0;
            idleCnt        <= '0;
            credits        <= CreditW'(FifoDepth);
            summaryValid   <= 1'b0;
            droppedWindows <= '0;
        end else begin
            summaryValid <= windowEnd && canSend;
            credits <= credits - CreditW'(windowEnd && canSend) + CreditW'(creditReturn);
            if (windowEnd && !canSend) begin
                droppedWindows <= droppedWindows + 16'd1;  // No room downstream
            end

            if (windowEnd) begin
                total      <= '0;
                computeCnt <= '0;
                memCnt     <= '0;
                controlCnt <= '0;
            end else begin
                total      <= nextTotal;
                computeCnt <= nextCompute;
                memCnt     <= nextMem;
                controlCnt <= nextControl;
            end

            if (instr.valid) begin
                idleCnt <= '0;
            end else if (idleCnt != IdleW'(IdleLimit)) begin
                idleCnt <= idleCnt + IdleW'(1);
            end
        end
    end

    // Summary payload, qualified by summaryValid
    always_ff @(posedge clk) begin
        if (windowEnd) begin
            summary.total      <= nextTotal;
            summary.computeCnt <= nextCompute;
            summary.memCnt     <= nextMem;
            summary.controlCnt <= nextControl;
            summary.idle       <= idleFire;
        end
    end

endmodule

// ==== summaryFifo.sv ====
module summaryFifo #(
    parameter int  Depth     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t headData,
    output logic     headValid,
    output logic     creditReturn
);

    localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountW = $clog2(Depth + 1);

    payload_t        mem [Depth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CountW-1:0] count;

    // Wraps at Depth, so any depth works
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        logic [PtrW-1:0] result;
        if (ptr == PtrW'(Depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + PtrW'(1);
        end
        return result;
    endfunction

    assign headData  = mem[rdPtr];
    assign headValid = (count != '0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            rdPtr        <= '0;
            wrPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= pop;  // One credit back per entry taken
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Sender holds credits, so push never meets a full queue
            case ({push, pop})
                2'b10:   count <= count + CountW'(1);
                2'b01:   count <= count - CountW'(1);
                default: ;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

// ==== formatDecider.sv ====
module formatDecider #(
    parameter int ConfThreshold = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  wlcPkg::winSummary_t  headSummary,
    input  logic                 headValid,
    input  logic                 resultReady,
    output logic                 pop,
    output wlcPkg::classResult_t result,
    output logic                 resultValid,
    output logic                 classificationValid,
    output logic [15:0]          classificationCount
);
    import wlcPkg::*;

    logic [7:0] computeToll;
    logic [7:0] memToll;
    logic [7:0] controlToll;
    logic [1:0] busyClasses;
    wlFormat_e  nextFormat;
    logic [3:0] baseConf;
    logic [3:0] nextConf;

    // count * TollScale / total, capped at 255
    function automatic logic [7:0] tollOf(input logic [7:0] cnt, input logic [7:0] total);
        logic [15:0] scaled;
        logic [7:0]  toll;
        toll = 8'd0;
        if (total != 8'd0) begin
            scaled = (16'(cnt) * 16'(TollScale)) / 16'(total);
            toll = (scaled > 16'd255) ? 8'd255 : scaled[7:0];
        end
        return toll;
    endfunction

    function automatic logic dominates(input logic [7:0] a, input logic [7:0] b,
                                       input logic [7:0] c);
        return (int'(a) > DominantLevel) &&
               (int'(a) > int'(b) + DominantMargin) &&
               (int'(a) > int'(c) + DominantMargin);
    endfunction

    assign computeToll = tollOf(headSummary.computeCnt, headSummary.total);
    assign memToll     = tollOf(headSummary.memCnt, headSummary.total);
    assign controlToll = tollOf(headSummary.controlCnt, headSummary.total);

    assign busyClasses = 2'(int'(computeToll) > MixedLevel) +
                         2'(int'(memToll) > MixedLevel) +
                         2'(int'(controlToll) > MixedLevel);

    // Priority order matters here
    always_comb begin
        if (headSummary.idle) begin
            nextFormat = FmtIdle;
            baseConf   = 4'd8;
        end else if (dominates(computeToll, memToll, controlToll)) begin
            nextFormat = FmtCompute;
            baseConf   = 4'd7;
        end else if (dominates(memToll, computeToll, controlToll)) begin
            nextFormat = FmtMemory;
            baseConf   = 4'd7;
        end else if (dominates(controlToll, computeToll, memToll)) begin
            nextFormat = FmtControl;
            baseConf   = 4'd7;
        end else if (busyClasses >= 2'd2) begin
            nextFormat = FmtMixed;
            baseConf   = 4'd6;
        end else begin
            nextFormat = FmtUnknown;
            baseConf   = 4'd4;
        end
    end

    // Same format as the last result builds confidence
    always_comb begin
        if (nextFormat == result.format && nextFormat != FmtUnknown) begin
            nextConf = (result.confidence > 4'd13) ? 4'd15 : result.confidence + 4'd2;
        end else begin
            nextConf = baseConf;
        end
    end

    // Take a summary when the output slot is free or leaving
    assign pop = headValid && (!resultValid || resultReady);

    assign classificationValid = (result.confidence >= 4'(ConfThreshold)) &&
                                 (result.format != FmtUnknown);

    always_ff @(posedge clk) begin
        if (!reset) begin
            result              <= '{format: FmtUnknown, default: '0};
            resultValid         <= 1'b0;
            classificationCount <= '0;
        end else begin
            if (pop) begin
                result.format       <= nextFormat;
                result.confidence   <= nextConf;
                result.computeToll  <= computeToll;
                result.memToll      <= memToll;
                result.controlToll  <= controlToll;
                resultValid         <= 1'b1;
                classificationCount <= classificationCount + 16'd1;
            end else if (resultReady) begin
                resultValid <= 1'b0;  // Taken, nothing new behind it
            end
        end
    end

endmodule

// ==== wlcTop.sv ====
module wlcTop #(
    parameter int WindowLen     = wlcPkg::DefWindowLen,
    parameter int IdleLimit     = wlcPkg::DefIdleLimit,
    parameter int FifoDepth     = wlcPkg::DefFifoDepth,
    parameter int ConfThreshold = wlcPkg::DefConfThreshold
) (
    input  logic                 clk,
    input  logic                 reset,
    input  wlcPkg::instrBeat_t   instr,
    input  logic                 resultReady,
    output wlcPkg::classResult_t result,
    output logic                 resultValid,
    output logic                 classificationValid,
    output logic [15:0]          classificationCount,
    output logic [15:0]          droppedWindows
);
    import wlcPkg::*;

    winSummary_t summary;
    winSummary_t headSummary;
    logic        summaryValid;
    logic        headValid;
    logic        pop;
    logic        creditReturn;

    // Producer, drops windows when out of credits
    opcodeWindow #(
        .WindowLen (WindowLen),
        .IdleLimit (IdleLimit),
        .FifoDepth (FifoDepth)
    ) u_window (
        .clk            (clk),
        .reset          (reset),
        .instr          (instr),
        .creditReturn   (creditReturn),
        .summary        (summary),
        .summaryValid   (summaryValid),
        .droppedWindows (droppedWindows)
    );

    summaryFifo #(
        .Depth     (FifoDepth),
        .payload_t (winSummary_t)
    ) u_fifo (
        .clk          (clk),
        .reset        (reset),
        .push         (summaryValid),
        .pushData     (summary),
        .pop          (pop),
        .headData     (headSummary),
        .headValid    (headValid),
        .creditReturn (creditReturn)
    );

    formatDecider #(
        .ConfThreshold (ConfThreshold)
    ) u_decider (
        .clk                 (clk),
        .reset               (reset),
        .headSummary         (headSummary),
        .headValid           (headValid),
        .resultReady         (resultReady),
        .pop                 (pop),
        .result              (result),
        .resultValid         (resultValid),
        .classificationValid (classificationValid),
        .classificationCount (classificationCount)
    );

endmodule

// ==== wlcModel.svh ====
`ifndef WLC_MODEL_SVH
`define WLC_MODEL_SVH

// Reference decision constants for tolls in 0..255
localparam int RefTollScale      = 200;
localparam int RefDominantLevel  = 150;
localparam int RefDominantMargin = 80;
localparam int RefMixedLevel     = 50;

function automatic int scaledToll(input int cnt, input int total);
    int toll;
    toll = (total == 0) ? 0 : cnt * RefTollScale / total;
    return (toll > 255) ? 255 : toll;
endfunction

function automatic bit isDominant(input int a, input int b, input int c);
    return a > RefDominantLevel && a > b + RefDominantMargin && a > c + RefDominantMargin;
endfunction

// Format codes follow the package enum from 0 Unknown to 5 Idle
function automatic int classifyWindow(input winSummary_t w);
    int c;
    int m;
    int k;
    c = scaledToll(int'(w.computeCnt), int'(w.total));
    m = scaledToll(int'(w.memCnt), int'(w.total));
    k = scaledToll(int'(w.controlCnt), int'(w.total));
    if (w.idle) return 5;
    if (isDominant(c, m, k)) return 1;
    if (isDominant(m, c, k)) return 2;
    if (isDominant(k, c, m)) return 3;
    if (int'(c > RefMixedLevel) + int'(m > RefMixedLevel) +
        int'(k > RefMixedLevel) >= 2) return 4;
    return 0;
endfunction

// Repeats of a known format climb by 2 up to 15
function automatic int nextConfidence(input int fmt, input int prevFmt, input int prevConf);
    if (fmt == prevFmt && fmt != 0) return (prevConf + 2 > 15) ? 15 : prevConf + 2;
    case (fmt)
        5: return 8;
        1, 2, 3: return 7;
        4: return 6;
        default: return 4;
    endcase
endfunction

`endif

// ==== wlcTb.sv ====
module wlcTb;
    timeunit 1ns;
    timeprecision 1ps;
    import wlcPkg::*;

    `include "wlcModel.svh"

    logic         clk = 1'b0;
    logic         reset;
    instrBeat_t   instr;
    logic         resultReady;
    classResult_t result;
    logic         resultValid;
    logic         classificationValid;
    logic [15:0]  classificationCount;
    logic [15:0]  droppedWindows;

    byte         cmdQ[$];  // I, G and R commands in file order
    int          argAQ[$];
    int          argBQ[$];
    int          expFormatQ[$];
    int          expConfQ[$];
    winSummary_t windowQ[$];  // Windows expected to reach the output
    int          expDropped = 0;
    int          expCount = 0;
    int          cycleLimit = 200;
    int          cycles = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          winTotal = 0;
    int          winCompute = 0;
    int          winMem = 0;
    int          winControl = 0;
    int          idleRun = 0;
    int          heldWindows = 0;
    int          prevFormat = 0;  // Output register resets to Unknown
    int          prevConf = 0;

    wlcTop u_dut (
        .clk                 (clk),
        .reset               (reset),
        .instr               (instr),
        .resultReady         (resultReady),
        .result              (result),
        .resultValid         (resultValid),
        .classificationValid (classificationValid),
        .classificationCount (classificationCount),
        .droppedWindows      (droppedWindows)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            valueErrors++;
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic printCounts();
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    endtask

    task automatic readStim();
        int    fd;
        int    a;
        int    b;
        int    total;
        byte   cmd;
        string line;
        total = 0;
        fd = $fopen("wlcStim.txt", "r");
        assert (fd != 0) else begin
            otherErrors++;
            $display("Could not open wlcStim.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            cmd = line.getc(0);
            a = 0;
            b = 0;
            if (cmd == "I") void'($sscanf(line.substr(2, line.len() - 1), "%h %d", a, b));
            else void'($sscanf(line.substr(2, line.len() - 1), "%d %d", a, b));
            case (cmd)
                "E": begin
                    expFormatQ.push_back(a);
                    expConfQ.push_back(b);
                    expCount++;
                end
                "D": expDropped = a;
                default: begin
                    cmdQ.push_back(cmd);
                    argAQ.push_back(a);
                    argBQ.push_back(b);
                    total += (cmd == "I") ? b : (cmd == "G") ? a : 0;
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        cycleLimit = 2 * total + 200;
    endtask

    // Held results fill the output register and FIFO before windows drop
    task automatic closeWindow(input logic idle);
        winSummary_t w;
        w.total      = 8'(winTotal);
        w.computeCnt = 8'(winCompute);
        w.memCnt     = 8'(winMem);
        w.controlCnt = 8'(winControl);
        w.idle       = idle;
        if (resultReady || heldWindows < DefFifoDepth + 1) windowQ.push_back(w);
        heldWindows++;
        winTotal   = 0;
        winCompute = 0;
        winMem     = 0;
        winControl = 0;
    endtask

    task automatic driveBeat(input logic valid, input opcode_t op);
        instr.valid  = valid;
        instr.opcode = op;
        if (valid) begin
            idleRun = 0;
            winTotal++;
            case (op)
                OpAluReg, OpAluImm:      winCompute++;
                OpLoad, OpStore:         winMem++;
                OpBranch, OpJal, OpJalr: winControl++;
                default: ;
            endcase
            if (winTotal == DefWindowLen) closeWindow(1'b0);
        end else begin
            idleRun++;
            if (idleRun == DefIdleLimit) closeWindow(1'b1);  // Once per idle run
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compareResult();
        winSummary_t w;
        int          fmt;
        int          conf;
        assert (expFormatQ.size() != 0 && windowQ.size() != 0) else begin
            otherErrors++;
            $display("A result was transferred with no expected entry or window left");
        end
        if (expFormatQ.size() != 0 && windowQ.size() != 0) begin
            w    = windowQ.pop_front();
            fmt  = classifyWindow(w);
            conf = nextConfidence(fmt, prevFormat, prevConf);
            checkValue("result.format", int'(result.format), expFormatQ.pop_front());
            checkValue("result.confidence", int'(result.confidence), expConfQ.pop_front());
            checkValue("result.format", int'(result.format), fmt);
            checkValue("result.confidence", int'(result.confidence), conf);
            checkValue("result.computeToll", int'(result.computeToll),
                       scaledToll(int'(w.computeCnt), int'(w.total)));
            checkValue("result.memToll", int'(result.memToll),
                       scaledToll(int'(w.memCnt), int'(w.total)));
            checkValue("result.controlToll", int'(result.controlToll),
                       scaledToll(int'(w.controlCnt), int'(w.total)));
            checkValue("classificationValid", int'(classificationValid),
                       int'(conf >= DefConfThreshold && fmt != 0));
            prevFormat = fmt;
            prevConf   = conf;
        end
    endtask

    // Sampled mid cycle away from both clock edges
    always @(negedge clk) begin
        if (reset && resultValid && resultReady) compareResult();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles with results still outstanding", cycles);
            printCounts();
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b0;
        instr       = '0;
        resultReady = 1'b0;
        readStim();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b1;
        checkValue("resultValid", int'(resultValid), 0);
        checkValue("classificationCount", int'(classificationCount), 0);
        checkValue("droppedWindows", int'(droppedWindows), 0);
        foreach (cmdQ[i]) begin
            case (cmdQ[i])
                "R": begin
                    resultReady = (argAQ[i] != 0);
                    heldWindows = 0;
                end
                "I": repeat (argBQ[i]) driveBeat(1'b1, opcode_t'(argAQ[i]));
                "G": repeat (argAQ[i]) driveBeat(1'b0, '0);
                default: begin
                    otherErrors++;
                    $display("Unknown command in the stimulus file");
                end
            endcase
        end
        while (expFormatQ.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
        checkValue("droppedWindows", int'(droppedWindows), expDropped);
        checkValue("classificationCount", int'(classificationCount), expCount);
        assert (windowQ.size() == 0) else begin
            otherErrors++;
            $display("%0d finished windows never produced a result", windowQ.size());
        end
        printCounts();
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
wlcPkg.sv
opcodeWindow.sv
summaryFifo.sv
formatDecider.sv
wlcTop.sv
wlcTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps --top-module wlcTb \
    -f build.f -o wlcSim && ./obj_dir/wlcSim; } > sim.log 2>&1 || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

// ==== wlcStim.txt ====
# I opcode(hex) count | G idle cycles | R ready level | E format confidence | D final drops
# Formats 0 Unknown, 1 Compute, 2 Memory, 3 Control, 4 Mixed, 5 Idle
R 1
I 33 96
E 1 7
E 1 9
E 1 11
E 1 13
E 1 15
E 1 15
I 03 32
E 2 7
E 2 9
I 63 8
I 6f 8
E 3 7
I 67 16
E 3 9
I 33 8
I 23 8
E 4 6
I 13 5
G 30
E 5 8
I 37 16
E 0 4
G 8
R 0
I 33 128
G 8
R 1
E 1 7
E 1 9
E 1 11
E 1 13
E 1 15
D 3
